//--- common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// panel data bus, one byte per transfer
	typedef logic [7:0] lcd_data_t;

	// register block word address and bus data
	typedef logic [1:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// one queued transfer, same layout as reg_write bits 9..0
	typedef struct packed {
		logic      rs;   // 0 = instruction, 1 = data
		logic      rw;   // driven out only, never sampled
		lcd_data_t data;
	} lcd_word_t;

	// init flags, same layout as reg_ctrl bits 6..0
	typedef struct packed {
		logic two_line;   // N bit of function set
		logic font_5x10;  // F bit of function set
		logic display_on; // D
		logic cursor_on;  // C
		logic blink_on;   // B
		logic increment;  // I/D of entry mode
		logic shift;      // S of entry mode
	} lcd_cfg_t;

	typedef enum logic [2:0] {
		st_powerup,    // panel supply settling
		st_wait_start, // idle until start bit
		st_init,       // four-command init sequence
		st_ready,      // waiting on the queue
		st_write       // one word on the pins
	} ctrl_state_t;

	// register word offsets
	localparam wb_addr_t reg_ctrl   = 2'd0;
	localparam wb_addr_t reg_status = 2'd1;
	localparam wb_addr_t reg_write  = 2'd2;

	// bit positions inside the registers
	localparam int ctrl_start_bit   = 8;
	localparam int stat_done_bit    = 0;
	localparam int stat_busy_bit    = 1;
	localparam int stat_full_bit    = 2;

	// delays in microseconds, scaled by cycles_per_us in the controller
	localparam int us_powerup    = 500;
	localparam int us_init_pulse = 10;
	localparam int us_gap_fset   = 50;
	localparam int us_gap_disp   = 50;
	localparam int us_gap_clear  = 200;
	localparam int us_gap_entry  = 100;
	localparam int us_wr_setup   = 1;  // e low before the pulse
	localparam int us_wr_pulse   = 13; // e high
	localparam int us_wr_total   = 50; // whole transfer

endpackage

`default_nettype wire

//--- lcd/lcd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl import lcd_pkg::*; #(
	parameter int cycles_per_us = 30
) (
	input  wire        clk,
	input  wire        reset,
	input  lcd_cfg_t   cfg,
	input  wire        start_req,
	output logic       init_done,
	output logic       busy,
	input  wire        valid,
	input  lcd_word_t  head,
	output logic       pop,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output lcd_data_t  lcd_data
);

	// power-up is the longest interval the counter has to cover
	localparam int cw = $clog2(us_powerup * cycles_per_us);
	typedef logic [cw-1:0] cnt_t;

	localparam cnt_t powerup_last = cnt_t'(us_powerup * cycles_per_us - 1);
	localparam cnt_t init_pulse   = cnt_t'(us_init_pulse * cycles_per_us);
	localparam cnt_t wr_rise      = cnt_t'(us_wr_setup * cycles_per_us);
	localparam cnt_t wr_fall      = cnt_t'((us_wr_setup + us_wr_pulse) * cycles_per_us);
	localparam cnt_t wr_last      = cnt_t'(us_wr_total * cycles_per_us - 1);

	ctrl_state_t state;
	cnt_t        cnt;        // cycles within the current interval
	logic [1:0]  step;       // init command index
	logic        start_pend; // start seen during power-up
	lcd_cfg_t    cfg_q;
	lcd_word_t   word_q;

	// last count of each init step, pulse plus gap
	function automatic cnt_t step_last(input logic [1:0] s);
		int us;
		case (s)
			2'd0:    us = us_init_pulse + us_gap_fset;
			2'd1:    us = us_init_pulse + us_gap_disp;
			2'd2:    us = us_init_pulse + us_gap_clear;
			default: us = us_init_pulse + us_gap_entry;
		endcase
		return cnt_t'(us * cycles_per_us - 1);
	endfunction

	function automatic lcd_data_t init_cmd(input logic [1:0] s, input lcd_cfg_t c);
		lcd_data_t d;
		case (s)
			2'd0:    d = {4'b0011, c.two_line, c.font_5x10, 2'b00}; // function set
			2'd1:    d = {5'b00001, c.display_on, c.cursor_on, c.blink_on};
			2'd2:    d = 8'b0000_0001; // clear
			default: d = {6'b000001, c.increment, c.shift};
		endcase
		return d;
	endfunction

	assign pop  = (state == st_ready) && valid;
	assign busy = (state != st_ready) || pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_powerup;
			cnt        <= '0;
			step       <= '0;
			start_pend <= 1'b0;
			init_done  <= 1'b0;
		end else begin
			case (state)
				st_powerup: begin
					if (start_req)
						start_pend <= 1'b1; // keep it until the wait ends
					if (cnt == powerup_last) begin
						cnt   <= '0;
						state <= st_wait_start;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_wait_start: begin
					if (start_pend || start_req) begin
						start_pend <= 1'b0;
						step       <= '0;
						cnt        <= '0;
						state      <= st_init;
					end
				end
				st_init: begin
					if (cnt == step_last(step)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							init_done <= 1'b1; // sticky until reset
							state     <= st_ready;
						end else begin
							step <= step + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_ready: begin
					if (valid) begin
						cnt   <= '0;
						state <= st_write;
					end
				end
				st_write: begin
					if (cnt == wr_last) begin
						cnt   <= '0;
						state <= st_ready;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_powerup;
			endcase
		end
	end

	// flags are frozen for the whole sequence
	always_ff @(posedge clk) begin
		if (state == st_wait_start && (start_pend || start_req))
			cfg_q <= cfg;
		if (pop)
			word_q <= head;
	end

	// pin drive, decoded from state and counter
	always_comb begin
		e        = 1'b0;
		rs       = 1'b0;
		rw       = 1'b0;
		lcd_data = '0;
		case (state)
			st_init: begin
				if (cnt < init_pulse) begin
					e        = 1'b1;
					lcd_data = init_cmd(step, cfg_q);
				end
			end
			st_write: begin
				rs       = word_q.rs;
				rw       = word_q.rw;
				lcd_data = word_q.data;
				e        = (cnt >= wr_rise) && (cnt < wr_fall);
			end
			default: ;
		endcase
	end

	// init pulses only before init_done, write pulses only after it
	a_e_state: assert property (@(posedge clk) disable iff (reset)
		e |-> (state == st_init && !init_done) || (state == st_write && init_done));

	// panel latches on the falling edge, so the bus must not move under e
	a_bus_stable: assert property (@(posedge clk) disable iff (reset)
		e && $past(e) |-> $stable({rs, rw, lcd_data}));

	// a pop hands the word straight to a single transfer
	a_pop_ready: assert property (@(posedge clk) disable iff (reset)
		pop |-> (state == st_ready) ##1 (state == st_write && !pop));

endmodule

`default_nettype wire

//--- hw/lcd_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_fifo import lcd_pkg::*; #(
	parameter int fifo_depth = 4
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        push,
	input  lcd_word_t  push_word,
	output logic       full,
	input  wire        pop,
	output logic       valid,
	output lcd_word_t  head
);

	localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cntw = $clog2(fifo_depth + 1);

	typedef logic [aw-1:0]   ptr_t;
	typedef logic [cntw-1:0] count_t;

	localparam ptr_t   ptr_last  = ptr_t'(fifo_depth - 1);
	localparam count_t count_max = count_t'(fifo_depth);

	lcd_word_t mem [fifo_depth];
	ptr_t      wr_ptr;
	ptr_t      rd_ptr;
	count_t    count;

	assign full  = (count == count_max);
	assign valid = (count != '0);
	assign head  = mem[rd_ptr]; // oldest entry

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> valid);

endmodule

`default_nettype wire

//--- hw/lcd_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_wb_regs import lcd_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        cyc,
	input  wire        stb,
	input  wire        we,
	input  wb_addr_t   adr,
	input  wb_data_t   dat_i,
	output wb_data_t   dat_o,
	output logic       ack,
	output lcd_cfg_t   cfg,
	output logic       start_req,
	input  wire        init_done,
	input  wire        busy,
	output logic       push,
	output lcd_word_t  push_word,
	input  wire        full
);

	logic req;     // new request, not yet acked
	logic wr_fifo; // write aimed at the queue
	logic accept;  // request taken this clock

	assign req     = cyc && stb && !ack;
	assign wr_fifo = we && (adr == reg_write);
	// a queue write waits here while the queue is full
	assign accept  = req && !(wr_fifo && full);

	always_ff @(posedge clk) begin
		if (reset) begin
			ack       <= 1'b0;
			push      <= 1'b0;
			start_req <= 1'b0;
			cfg       <= '0;
		end else begin
			ack       <= accept;
			push      <= accept && wr_fifo; // lands with the ack
			start_req <= accept && we && (adr == reg_ctrl) && dat_i[ctrl_start_bit];
			if (accept && we && adr == reg_ctrl)
				cfg <= lcd_cfg_t'(dat_i[$bits(lcd_cfg_t)-1:0]);
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (accept && wr_fifo)
			push_word <= lcd_word_t'(dat_i[$bits(lcd_word_t)-1:0]);
		if (accept && !we) begin
			dat_o <= '0;
			case (adr)
				reg_ctrl: dat_o[$bits(lcd_cfg_t)-1:0] <= cfg;
				reg_status: begin
					dat_o[stat_done_bit] <= init_done;
					dat_o[stat_busy_bit] <= busy;
					dat_o[stat_full_bit] <= full;
				end
				default: ; // write-only or unmapped, reads zero
			endcase
		end
	end

	// ack follows an open cycle one clock later, master must still hold it
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		ack |-> cyc && stb);

endmodule

`default_nettype wire

//--- hw/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top import lcd_pkg::*; #(
	parameter int cycles_per_us = 30,
	parameter int fifo_depth    = 4
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        cyc,
	input  wire        stb,
	input  wire        we,
	input  wb_addr_t   adr,
	input  wb_data_t   dat_i,
	output wb_data_t   dat_o,
	output logic       ack,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output lcd_data_t  lcd_data
);

	lcd_cfg_t  cfg;
	logic      start_req;
	logic      init_done;
	logic      busy;
	logic      push;
	lcd_word_t push_word;
	logic      full;
	logic      valid;
	lcd_word_t head;
	logic      pop;

	lcd_wb_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack       (ack),
		.cfg       (cfg),
		.start_req (start_req),
		.init_done (init_done),
		.busy      (busy),
		.push      (push),
		.push_word (push_word),
		.full      (full)
	);

	lcd_cmd_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.push_word (push_word),
		.full      (full),
		.pop       (pop),
		.valid     (valid),
		.head      (head)
	);

	lcd_ctrl #(
		.cycles_per_us (cycles_per_us)
	) u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.start_req (start_req),
		.init_done (init_done),
		.busy      (busy),
		.valid     (valid),
		.head      (head),
		.pop       (pop),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

`default_nettype wire

//--- verif/lcd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_tb import lcd_pkg::*; ();

	localparam int n           = 2;      // cycles per microsecond
	localparam int init_high   = 10 * n; // e high, init step
	localparam int write_high  = 13 * n; // e high, queued word
	localparam int min_rise    = 50 * n; // rise to rise, one transfer
	localparam int ack_timeout = 500;    // cycles
	localparam int poll_limit  = 2000;   // status reads

	logic      clk;
	logic      reset;
	logic      cyc;
	logic      stb;
	logic      we;
	wb_addr_t  adr;
	wb_data_t  dat_i;
	wb_data_t  dat_o;
	logic      ack;
	logic      e;
	logic      rs;
	logic      rw;
	lcd_data_t lcd_data;

	logic [9:0] exp_word [$]; // {rs, rw, data} in pin order
	int         exp_len [$];  // expected e high cycles per word
	int         words_sent;
	int         words_seen;
	int         errors;

	lcd_top #(
		.cycles_per_us (n),
		.fifo_depth    (4)
	) uut (
		.clk      (clk),
		.reset    (reset),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_i    (dat_i),
		.dat_o    (dat_o),
		.ack      (ack),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_run();
		errors++;
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %t: %s is %h, expected %h", $time, name, actual, expected);
			stop_run();
		end
	endtask

	// one Wishbone classic cycle, ack sampled on the falling clock edge
	task automatic bus_cycle(input logic write, input wb_addr_t a, input wb_data_t d,
			output wb_data_t q);
		int waited;
		waited = 0;
		q = '0;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= write;
		adr   <= a;
		dat_i <= d;
		@(negedge clk);
		while (!ack) begin
			if (waited >= ack_timeout) begin
				$display("no bus acknowledge within %0d cycles at %t", ack_timeout, $time);
				stop_run();
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		q = dat_o;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic bus_write(input wb_addr_t a, input wb_data_t d);
		wb_data_t unused;
		bus_cycle(1'b1, a, d, unused);
	endtask

	task automatic bus_read(input wb_addr_t a, output wb_data_t q);
		bus_cycle(1'b0, a, '0, q);
	endtask

	task automatic expect_word(input logic [9:0] w, input int len);
		exp_word.push_back(w);
		exp_len.push_back(len);
		words_sent++;
	endtask

	task automatic send_word(input logic [9:0] w);
		expect_word(w, write_high);
		bus_write(reg_write, wb_data_t'(w));
	endtask

	task automatic wait_init_done();
		wb_data_t st;
		int       polls;
		polls = 0;
		bus_read(reg_status, st);
		while (!st[0]) begin
			if (polls >= poll_limit) begin
				$display("init_done never rose after %0d status reads", poll_limit);
				stop_run();
			end else begin
				polls++;
				bus_read(reg_status, st);
			end
		end
	endtask

	// all expected words seen and the controller idle with an empty queue
	task automatic wait_idle();
		wb_data_t st;
		int       polls;
		polls = 0;
		bus_read(reg_status, st);
		while (st[1] || exp_word.size() != 0) begin
			if (polls >= poll_limit) begin
				$display("controller still busy after %0d status reads", poll_limit);
				stop_run();
			end else begin
				polls++;
				bus_read(reg_status, st);
			end
		end
	endtask

	always @(negedge clk) begin : pin_monitor
		logic [9:0] want;
		int         want_len;
		static int         cycle_no  = 0;
		static int         hi_len    = 0;
		static int         last_rise = 0;
		static bit         had_rise  = 1'b0;
		static logic       e_prev    = 1'b0;
		static logic [9:0] seen      = '0;
		cycle_no++;
		if (reset) begin
			e_prev = 1'b0;
			hi_len = 0;
		end else begin
			if (e && !e_prev) begin
				if (had_rise)
					compare_value("e_rise_spacing_ok", (cycle_no - last_rise) >= min_rise, 1);
				last_rise = cycle_no;
				had_rise  = 1'b1;
			end
			if (e) begin
				hi_len++;
				seen = {rs, rw, lcd_data}; // last value before the fall
			end else if (e_prev) begin
				if (exp_word.size() == 0) begin
					$display("enable pulse at %t with no word expected", $time);
					stop_run();
				end else begin
					want     = exp_word.pop_front();
					want_len = exp_len.pop_front();
					compare_value("rs", seen[9], want[9]);
					compare_value("rw", seen[8], want[8]);
					compare_value("lcd_data", seen[7:0], want[7:0]);
					compare_value("e_high_cycles", hi_len, want_len);
					words_seen++;
				end
				hi_len = 0;
			end
			e_prev = e;
		end
	end

	initial begin : main
		wb_data_t   rdata;
		logic [6:0] flags;
		int         gap;
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(4));
		words_sent = 0;
		words_seen = 0;
		errors     = 0;
		reset = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_i = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		bus_read(reg_status, rdata);
		compare_value("init_done", rdata[0], 1'b0);
		compare_value("busy", rdata[1], 1'b1);

		// random flags, start bit set in the same write
		flags = 7'($urandom);
		expect_word({2'b00, 4'b0011, flags[6], flags[5], 2'b00}, init_high); // function set
		expect_word({2'b00, 5'b00001, flags[4], flags[3], flags[2]}, init_high);
		expect_word({2'b00, 8'h01}, init_high); // clear
		expect_word({2'b00, 6'b000001, flags[1], flags[0]}, init_high);
		bus_write(reg_ctrl, wb_data_t'(flags) | (32'h1 << 8));
		bus_read(reg_ctrl, rdata);
		compare_value("cfg", rdata[6:0], flags);

		wait_init_done();
		compare_value("init_words_seen", words_seen, 4);
		bus_read(reg_status, rdata);
		compare_value("init_done", rdata[0], 1'b1);

		for (int i = 0; i < 60; i++) begin
			send_word(10'($urandom));
			gap = $urandom_range(150, 0);
			repeat (gap) @(posedge clk);
		end
		wait_idle();

		// back-to-back bursts, one word on the pins and four in the queue
		for (int b = 0; b < 3; b++) begin
			wait_idle();
			for (int i = 0; i < 5; i++)
				send_word(10'($urandom));
			bus_read(reg_status, rdata);
			compare_value("queue_full", rdata[2], 1'b1);
			for (int i = 0; i < 4; i++)
				send_word(10'($urandom)); // these stall on the full queue
		end
		wait_idle();
		compare_value("words_seen", words_seen, words_sent);

		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
common/lcd_pkg.sv
lcd/lcd_ctrl.sv
hw/lcd_cmd_fifo.sv
hw/lcd_wb_regs.sv
hw/lcd_top.sv
verif/lcd_tb.sv

//--- Bender.yml
package:
  name: lcd_wb_display

sources:
  # shared package first
  - common/lcd_pkg.sv
  # design
  - lcd/lcd_ctrl.sv
  - hw/lcd_cmd_fifo.sv
  - hw/lcd_wb_regs.sv
  - hw/lcd_top.sv
  # testbench
  - target: simulation
    files:
      - verif/lcd_tb.sv
